// ==== hw/beat_buffer.sv ====
`include "fetch_consts.svh"

module beat_buffer
(
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  i_wr_en,
    input  mem_side_pkg::beat_t   i_wr_data,
    input  column_pkg::byte_idx_t i_wr_start,
    input  column_pkg::byte_idx_t i_wr_end,
    input  mem_side_pkg::addr_t   i_wr_dst,
    input  logic                  i_wr_last,
    input  logic                  i_pop,
    output logic                  o_beat_valid,
    output mem_side_pkg::beat_t   o_beat_data,
    output column_pkg::byte_idx_t o_beat_start,
    output column_pkg::byte_idx_t o_beat_end,
    output mem_side_pkg::addr_t   o_beat_dst,
    output logic                  o_beat_last,
    output logic                  o_credit
);

    localparam int PW = $clog2(`FETCH_BUF_DEPTH);

    mem_side_pkg::beat_t   mem_data  [`FETCH_BUF_DEPTH];
    column_pkg::byte_idx_t mem_start [`FETCH_BUF_DEPTH];
    column_pkg::byte_idx_t mem_end   [`FETCH_BUF_DEPTH];
    mem_side_pkg::addr_t   mem_dst   [`FETCH_BUF_DEPTH];
    logic                  mem_last  [`FETCH_BUF_DEPTH];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [PW:0]           count;

    always_ff @(posedge clock)
    begin
        if (i_wr_en)
        begin
            mem_data[wr_ptr]  <= i_wr_data;
            mem_start[wr_ptr] <= i_wr_start;
            mem_end[wr_ptr]   <= i_wr_end;
            mem_dst[wr_ptr]   <= i_wr_dst;
            mem_last[wr_ptr]  <= i_wr_last;
        end
    end

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            wr_ptr   <= wr_ptr + {{(PW-1){1'b0}}, i_wr_en};
            rd_ptr   <= rd_ptr + {{(PW-1){1'b0}}, i_pop};
            count    <= count + {{PW{1'b0}}, i_wr_en} - {{PW{1'b0}}, i_pop};
            // each freed slot goes back to the issuer
            o_credit <= i_pop;
        end
    end

    assign o_beat_valid = (count != 0);
    assign o_beat_data  = mem_data[rd_ptr];
    assign o_beat_start = mem_start[rd_ptr];
    assign o_beat_end   = mem_end[rd_ptr];
    assign o_beat_dst   = mem_dst[rd_ptr];
    assign o_beat_last  = mem_last[rd_ptr];

    // the credit loop must keep the FIFO from overflowing
    a_no_overflow: assert property (@(posedge clock) disable iff (!resetn)
        !(i_wr_en && (count == `FETCH_BUF_DEPTH)));

    a_no_underflow: assert property (@(posedge clock) disable iff (!resetn)
        i_pop |-> o_beat_valid);

endmodule

// ==== hw/column_packer.sv ====
`include "fetch_consts.svh"

module column_packer
(
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  i_beat_valid,
    input  mem_side_pkg::beat_t   i_beat_data,
    input  column_pkg::byte_idx_t i_beat_start,
    input  column_pkg::byte_idx_t i_beat_end,
    input  mem_side_pkg::addr_t   i_beat_dst,
    input  logic                  i_beat_last,
    output logic                  o_pop,
    output logic                  o_out_valid,
    output mem_side_pkg::addr_t   o_out_addr,
    output mem_side_pkg::beat_t   o_out_data,
    input  logic                  i_out_done
);

    localparam int WORD_BITS = `FETCH_BEAT_BYTES * 8;
    localparam int ACC_BITS  = 2 * WORD_BITS - 8;

    column_pkg::pack_state_t state;
    logic [ACC_BITS-1:0]     acc;
    column_pkg::byte_cnt_t   acc_cnt;
    logic                    first;
    logic                    flush_pend;
    mem_side_pkg::addr_t     run_addr;

    mem_side_pkg::beat_t     ext;
    column_pkg::byte_cnt_t   ext_cnt;
    logic [ACC_BITS-1:0]     merged;
    column_pkg::byte_cnt_t   merged_cnt;
    mem_side_pkg::addr_t     base_addr;
    logic                    full_word;

    //////////////////////////////////////////////////////////////////////
    // byte extraction and append
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        ext_cnt = column_pkg::byte_cnt_t'(i_beat_end)
                - column_pkg::byte_cnt_t'(i_beat_start) + 6'd1;
        // bring byte start down to position 0, clear bytes past end
        ext = i_beat_data >> {i_beat_start, 3'b000};
        for (int b = 0; b < `FETCH_BEAT_BYTES; b++)
        begin
            if (b >= ext_cnt)
                ext[8*b +: 8] = 8'h00;
        end
        merged     = acc | ({{(ACC_BITS-WORD_BITS){1'b0}}, ext} << {acc_cnt, 3'b000});
        merged_cnt = acc_cnt + ext_cnt;
    end

    assign full_word = (merged_cnt >= `FETCH_BEAT_BYTES);
    assign base_addr = first ? i_beat_dst : run_addr;
    assign o_pop     = (state == column_pkg::COLLECT) && i_beat_valid;

    //////////////////////////////////////////////////////////////////////
    // packing FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            state       <= column_pkg::COLLECT;
            o_out_valid <= 1'b0;
            acc         <= '0;
            acc_cnt     <= '0;
            first       <= 1'b1;
            flush_pend  <= 1'b0;
        end
        else
        begin
            case (state)
                column_pkg::COLLECT:
                begin
                    if (o_pop)
                    begin
                        first <= i_beat_last;
                        if (full_word)
                        begin
                            o_out_valid <= 1'b1;
                            state       <= column_pkg::EMIT;
                            acc         <= merged >> WORD_BITS;
                            acc_cnt     <= merged_cnt - `FETCH_BEAT_BYTES;
                            flush_pend  <= i_beat_last && (merged_cnt != `FETCH_BEAT_BYTES);
                        end
                        else if (i_beat_last)
                        begin
                            // short tail, the word goes out zero padded
                            o_out_valid <= 1'b1;
                            state       <= column_pkg::EMIT;
                            acc         <= '0;
                            acc_cnt     <= '0;
                        end
                        else
                        begin
                            acc     <= merged;
                            acc_cnt <= merged_cnt;
                        end
                    end
                end
                column_pkg::EMIT:
                begin
                    if (i_out_done)
                    begin
                        o_out_valid <= 1'b0;
                        flush_pend  <= 1'b0;
                        state       <= flush_pend ? column_pkg::FLUSH : column_pkg::COLLECT;
                    end
                end
                column_pkg::FLUSH:
                begin
                    o_out_valid <= 1'b1;
                    acc         <= '0;
                    acc_cnt     <= '0;
                    state       <= column_pkg::EMIT;
                end
                default:
                    state <= column_pkg::COLLECT;
            endcase
        end
    end

    // output word and running target address
    always_ff @(posedge clock)
    begin
        if (o_pop)
        begin
            run_addr <= base_addr;
            if (full_word || i_beat_last)
            begin
                o_out_data <= merged[WORD_BITS-1:0];
                o_out_addr <= base_addr;
                run_addr   <= base_addr + `FETCH_BEAT_BYTES;
            end
        end
        else if (state == column_pkg::FLUSH)
        begin
            o_out_data <= acc[WORD_BITS-1:0];
            o_out_addr <= run_addr;
            run_addr   <= run_addr + `FETCH_BEAT_BYTES;
        end
    end

    a_word_stable: assert property (@(posedge clock) disable iff (!resetn)
        (o_out_valid && !i_out_done)
        |=> (o_out_valid && $stable(o_out_data) && $stable(o_out_addr)));

endmodule

// ==== hw/column_pkg.sv ====
package column_pkg;

    // byte position inside a beat
    typedef logic [3:0] byte_idx_t;

    // bytes held in the packing accumulator, up to 31
    typedef logic [5:0] byte_cnt_t;

    typedef enum logic [1:0]
    {
        COLLECT,
        EMIT,
        FLUSH
    } pack_state_t;

endpackage

// ==== hw/fetch_unit.sv ====
module fetch_unit
(
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     i_req_valid,
    input  mem_side_pkg::addr_t      i_req_src,
    input  mem_side_pkg::burst_len_t i_req_len,
    input  column_pkg::byte_idx_t    i_req_start,
    input  column_pkg::byte_idx_t    i_req_end,
    input  mem_side_pkg::addr_t      i_req_dst,
    output logic                     o_req_ready,
    output logic                     o_rd_req_valid,
    output mem_side_pkg::addr_t      o_rd_addr,
    output mem_side_pkg::burst_len_t o_rd_len,
    input  logic                     i_rd_req_ready,
    input  mem_side_pkg::beat_t      i_rd_data,
    input  logic                     i_rd_valid,
    input  logic                     i_rd_last,
    output logic                     o_out_valid,
    output mem_side_pkg::addr_t      o_out_addr,
    output mem_side_pkg::beat_t      o_out_data,
    input  logic                     i_out_done
);

    // issuer to buffer
    logic                  wr_en;
    mem_side_pkg::beat_t   wr_data;
    column_pkg::byte_idx_t wr_start;
    column_pkg::byte_idx_t wr_end;
    mem_side_pkg::addr_t   wr_dst;
    logic                  wr_last;
    logic                  credit;

    // buffer to packer
    logic                  beat_valid;
    mem_side_pkg::beat_t   beat_data;
    column_pkg::byte_idx_t beat_start;
    column_pkg::byte_idx_t beat_end;
    mem_side_pkg::addr_t   beat_dst;
    logic                  beat_last;
    logic                  pop;

    read_issuer u_issuer
    (
        .clock          (clock),
        .resetn         (resetn),
        .i_req_valid    (i_req_valid),
        .i_req_src      (i_req_src),
        .i_req_len      (i_req_len),
        .i_req_start    (i_req_start),
        .i_req_end      (i_req_end),
        .i_req_dst      (i_req_dst),
        .o_req_ready    (o_req_ready),
        .o_rd_req_valid (o_rd_req_valid),
        .o_rd_addr      (o_rd_addr),
        .o_rd_len       (o_rd_len),
        .i_rd_req_ready (i_rd_req_ready),
        .i_rd_data      (i_rd_data),
        .i_rd_valid     (i_rd_valid),
        .i_rd_last      (i_rd_last),
        .i_credit       (credit),
        .o_wr_en        (wr_en),
        .o_wr_data      (wr_data),
        .o_wr_start     (wr_start),
        .o_wr_end       (wr_end),
        .o_wr_dst       (wr_dst),
        .o_wr_last      (wr_last)
    );

    beat_buffer u_buffer
    (
        .clock        (clock),
        .resetn       (resetn),
        .i_wr_en      (wr_en),
        .i_wr_data    (wr_data),
        .i_wr_start   (wr_start),
        .i_wr_end     (wr_end),
        .i_wr_dst     (wr_dst),
        .i_wr_last    (wr_last),
        .i_pop        (pop),
        .o_beat_valid (beat_valid),
        .o_beat_data  (beat_data),
        .o_beat_start (beat_start),
        .o_beat_end   (beat_end),
        .o_beat_dst   (beat_dst),
        .o_beat_last  (beat_last),
        .o_credit     (credit)
    );

    column_packer u_packer
    (
        .clock        (clock),
        .resetn       (resetn),
        .i_beat_valid (beat_valid),
        .i_beat_data  (beat_data),
        .i_beat_start (beat_start),
        .i_beat_end   (beat_end),
        .i_beat_dst   (beat_dst),
        .i_beat_last  (beat_last),
        .o_pop        (pop),
        .o_out_valid  (o_out_valid),
        .o_out_addr   (o_out_addr),
        .o_out_data   (o_out_data),
        .i_out_done   (i_out_done)
    );

endmodule

// ==== hw/mem_side_pkg.sv ====
package mem_side_pkg;

    // byte address on the read bus
    typedef logic [31:0] addr_t;

    // one data beat, memory byte order
    typedef logic [127:0] beat_t;

    // burst length in beats, 1 to 4
    typedef logic [2:0] burst_len_t;

    // free beat buffer slots, 0 to 8
    typedef logic [3:0] credit_t;

    typedef enum logic [1:0]
    {
        IDLE,
        ADDR,
        WAIT_CREDIT
    } issue_state_t;

endpackage

// ==== hw/read_issuer.sv ====
`include "fetch_consts.svh"

module read_issuer
(
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     i_req_valid,
    input  mem_side_pkg::addr_t      i_req_src,
    input  mem_side_pkg::burst_len_t i_req_len,
    input  column_pkg::byte_idx_t    i_req_start,
    input  column_pkg::byte_idx_t    i_req_end,
    input  mem_side_pkg::addr_t      i_req_dst,
    output logic                     o_req_ready,
    output logic                     o_rd_req_valid,
    output mem_side_pkg::addr_t      o_rd_addr,
    output mem_side_pkg::burst_len_t o_rd_len,
    input  logic                     i_rd_req_ready,
    input  mem_side_pkg::beat_t      i_rd_data,
    input  logic                     i_rd_valid,
    input  logic                     i_rd_last,
    input  logic                     i_credit,
    output logic                     o_wr_en,
    output mem_side_pkg::beat_t      o_wr_data,
    output column_pkg::byte_idx_t    o_wr_start,
    output column_pkg::byte_idx_t    o_wr_end,
    output mem_side_pkg::addr_t      o_wr_dst,
    output logic                     o_wr_last
);

    localparam int QW = $clog2(`FETCH_REQ_DEPTH);

    // requests waiting for issue
    mem_side_pkg::addr_t      rq_src   [`FETCH_REQ_DEPTH];
    mem_side_pkg::burst_len_t rq_len   [`FETCH_REQ_DEPTH];
    column_pkg::byte_idx_t    rq_start [`FETCH_REQ_DEPTH];
    column_pkg::byte_idx_t    rq_end   [`FETCH_REQ_DEPTH];
    mem_side_pkg::addr_t      rq_dst   [`FETCH_REQ_DEPTH];
    logic [QW-1:0]            rq_wr;
    logic [QW-1:0]            rq_rd;
    logic [QW:0]              rq_cnt;

    // context of every burst on the bus, oldest at the head
    column_pkg::byte_idx_t    cq_start [`FETCH_REQ_DEPTH];
    column_pkg::byte_idx_t    cq_end   [`FETCH_REQ_DEPTH];
    mem_side_pkg::addr_t      cq_dst   [`FETCH_REQ_DEPTH];
    logic [QW-1:0]            cq_wr;
    logic [QW-1:0]            cq_rd;
    logic [QW:0]              cq_cnt;

    mem_side_pkg::issue_state_t state;
    mem_side_pkg::credit_t      credits;
    mem_side_pkg::credit_t      head_len;
    logic                       push;
    logic                       can_issue;
    logic                       issue;
    logic                       burst_done;

    assign o_req_ready = (rq_cnt != `FETCH_REQ_DEPTH);
    assign push        = i_req_valid && o_req_ready;
    assign head_len    = {1'b0, rq_len[rq_rd]};
    assign can_issue   = (rq_cnt != 0) && (cq_cnt != `FETCH_REQ_DEPTH) && (credits >= head_len);
    assign issue       = can_issue && (state != mem_side_pkg::ADDR);
    assign burst_done  = i_rd_valid && i_rd_last;

    //////////////////////////////////////////////////////////////////////
    // queues
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (push)
        begin
            rq_src[rq_wr]   <= i_req_src;
            rq_len[rq_wr]   <= i_req_len;
            rq_start[rq_wr] <= i_req_start;
            rq_end[rq_wr]   <= i_req_end;
            rq_dst[rq_wr]   <= i_req_dst;
        end
        if (issue)
        begin
            cq_start[cq_wr] <= rq_start[rq_rd];
            cq_end[cq_wr]   <= rq_end[rq_rd];
            cq_dst[cq_wr]   <= rq_dst[rq_rd];
        end
    end

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            rq_wr  <= '0;
            rq_rd  <= '0;
            rq_cnt <= '0;
            cq_wr  <= '0;
            cq_rd  <= '0;
            cq_cnt <= '0;
        end
        else
        begin
            rq_wr  <= rq_wr + {{(QW-1){1'b0}}, push};
            rq_rd  <= rq_rd + {{(QW-1){1'b0}}, issue};
            rq_cnt <= rq_cnt + {{QW{1'b0}}, push} - {{QW{1'b0}}, issue};
            cq_wr  <= cq_wr + {{(QW-1){1'b0}}, issue};
            cq_rd  <= cq_rd + {{(QW-1){1'b0}}, burst_done};
            cq_cnt <= cq_cnt + {{QW{1'b0}}, issue} - {{QW{1'b0}}, burst_done};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // issue FSM and credits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            state   <= mem_side_pkg::IDLE;
            credits <= mem_side_pkg::credit_t'(`FETCH_BUF_DEPTH);
        end
        else
        begin
            // debit the whole burst up front, one credit back per popped beat
            credits <= credits - (issue ? head_len : '0) + {3'b000, i_credit};
            case (state)
                mem_side_pkg::IDLE, mem_side_pkg::WAIT_CREDIT:
                begin
                    if (issue)
                        state <= mem_side_pkg::ADDR;
                    else if (rq_cnt != 0)
                        state <= mem_side_pkg::WAIT_CREDIT;
                    else
                        state <= mem_side_pkg::IDLE;
                end
                mem_side_pkg::ADDR:
                begin
                    if (i_rd_req_ready)
                        state <= mem_side_pkg::IDLE;
                end
                default:
                    state <= mem_side_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (issue)
        begin
            o_rd_addr <= rq_src[rq_rd];
            o_rd_len  <= rq_len[rq_rd];
        end
    end

    assign o_rd_req_valid = (state == mem_side_pkg::ADDR);

    // returning beats go straight to the buffer with the head context
    assign o_wr_en    = i_rd_valid;
    assign o_wr_data  = i_rd_data;
    assign o_wr_start = cq_start[cq_rd];
    assign o_wr_end   = cq_end[cq_rd];
    assign o_wr_dst   = cq_dst[cq_rd];
    assign o_wr_last  = i_rd_last;

    a_credit_bound: assert property (@(posedge clock) disable iff (!resetn)
        credits <= `FETCH_BUF_DEPTH);

    a_beat_has_context: assert property (@(posedge clock) disable iff (!resetn)
        i_rd_valid |-> (cq_cnt != 0));

endmodule

// ==== include/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// bytes per memory beat and per output word
`define FETCH_BEAT_BYTES 16

// beat buffer entries, also the starting credit count
`define FETCH_BUF_DEPTH 8

// request queue and in-flight context queue
`define FETCH_REQ_DEPTH 4

`define FETCH_MAX_BURST 4

`endif

// ==== list.f ====
+incdir+include
hw/mem_side_pkg.sv
hw/column_pkg.sv
hw/read_issuer.sv
hw/beat_buffer.sv
hw/column_packer.sv
hw/fetch_unit.sv
sim/mem_responder.sv
sim/fetch_unit_tb.sv

// ==== include/mem_pattern.svh ====
`ifndef MEM_PATTERN_SVH
`define MEM_PATTERN_SVH

// fill byte of the test memory folded from every bit of the byte address
`define MEM_BYTE(a) (8'((a) ^ ((a) >> 7) ^ ((a) >> 14) ^ ((a) >> 21) ^ ((a) >> 28)))

`endif

// ==== sim/fetch_unit_tb.sv ====
`include "fetch_consts.svh"
`include "mem_pattern.svh"

module fetch_unit_tb;

    localparam int NUM_REQ      = 200;
    localparam int STALL_AFTER  = 60;
    localparam int STALL_CYCLES = 300;

    logic                     clock;
    logic                     resetn;
    logic                     i_req_valid;
    mem_side_pkg::addr_t      i_req_src;
    mem_side_pkg::burst_len_t i_req_len;
    column_pkg::byte_idx_t    i_req_start;
    column_pkg::byte_idx_t    i_req_end;
    mem_side_pkg::addr_t      i_req_dst;
    logic                     o_req_ready;
    logic                     o_rd_req_valid;
    mem_side_pkg::addr_t      o_rd_addr;
    mem_side_pkg::burst_len_t o_rd_len;
    logic                     i_rd_req_ready;
    mem_side_pkg::beat_t      i_rd_data;
    logic                     i_rd_valid;
    logic                     i_rd_last;
    logic                     o_out_valid;
    mem_side_pkg::addr_t      o_out_addr;
    mem_side_pkg::beat_t      o_out_data;
    logic                     i_out_done;
    int                       beats_issued;

    // request list
    mem_side_pkg::addr_t      req_src   [NUM_REQ];
    mem_side_pkg::burst_len_t req_len   [NUM_REQ];
    column_pkg::byte_idx_t    req_start [NUM_REQ];
    column_pkg::byte_idx_t    req_end   [NUM_REQ];
    mem_side_pkg::addr_t      req_dst   [NUM_REQ];

    // expected words and the global beat count that completes each
    mem_side_pkg::beat_t      exp_data [$];
    mem_side_pkg::addr_t      exp_addr [$];
    int                       exp_beat [$];
    logic                     exp_pad  [$];

    int   total_beats;
    int   cycle_limit;
    int   cycles;
    int   req_sent;
    int   words_seen;
    int   padded_seen;
    int   done_wait;
    logic req_taken;
    logic hold_done;
    logic saw_ready_low;

    fetch_unit DUT
    (
        .clock          (clock),
        .resetn         (resetn),
        .i_req_valid    (i_req_valid),
        .i_req_src      (i_req_src),
        .i_req_len      (i_req_len),
        .i_req_start    (i_req_start),
        .i_req_end      (i_req_end),
        .i_req_dst      (i_req_dst),
        .o_req_ready    (o_req_ready),
        .o_rd_req_valid (o_rd_req_valid),
        .o_rd_addr      (o_rd_addr),
        .o_rd_len       (o_rd_len),
        .i_rd_req_ready (i_rd_req_ready),
        .i_rd_data      (i_rd_data),
        .i_rd_valid     (i_rd_valid),
        .i_rd_last      (i_rd_last),
        .o_out_valid    (o_out_valid),
        .o_out_addr     (o_out_addr),
        .o_out_data     (o_out_data),
        .i_out_done     (i_out_done)
    );

    mem_responder u_mem
    (
        .clock          (clock),
        .resetn         (resetn),
        .i_rd_req_valid (o_rd_req_valid),
        .i_rd_addr      (o_rd_addr),
        .i_rd_len       (o_rd_len),
        .o_rd_req_ready (i_rd_req_ready),
        .o_rd_data      (i_rd_data),
        .o_rd_valid     (i_rd_valid),
        .o_rd_last      (i_rd_last),
        .o_beats_issued (beats_issued)
    );

    always #10 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h",
                                        name, got, expected));
    endtask

    task automatic check_idle_outputs();
        check_value("o_out_valid", o_out_valid, 1'b0);
        check_value("o_rd_req_valid", o_rd_req_valid, 1'b0);
        check_value("o_req_ready", o_req_ready, 1'b1);
    endtask

    task automatic take_word();
        if (words_seen >= exp_data.size())
            stop_with_failure("an output word arrived after the last expected word");
        else
        begin
            check_value("o_out_data", o_out_data, exp_data[words_seen]);
            check_value("o_out_addr", o_out_addr, exp_addr[words_seen]);
            if (exp_pad[words_seen])
                padded_seen = padded_seen + 1;
            words_seen = words_seen + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic make_requests();
        int s;
        int e;
        for (int r = 0; r < NUM_REQ; r++)
        begin
            s = $urandom_range(15, 0);
            e = $urandom_range(15, s);
            // some whole-beat requests so words can end exactly on a beat
            if ($urandom_range(7, 0) == 0)
            begin
                s = 0;
                e = 15;
            end
            req_src[r]   = $urandom & 32'h00ff_fff0;
            req_len[r]   = mem_side_pkg::burst_len_t'($urandom_range(4, 1));
            req_start[r] = column_pkg::byte_idx_t'(s);
            req_end[r]   = column_pkg::byte_idx_t'(e);
            req_dst[r]   = $urandom & 32'hffff_fff0;
        end
    endtask

    task automatic add_expected(input mem_side_pkg::beat_t word, input mem_side_pkg::addr_t addr,
                                input int beat, input logic padded);
        exp_data.push_back(word);
        exp_addr.push_back(addr);
        exp_beat.push_back(beat);
        exp_pad.push_back(padded);
    endtask

    task automatic build_model();
        logic [7:0]          acc [$];
        mem_side_pkg::beat_t word;
        mem_side_pkg::addr_t addr;
        mem_side_pkg::addr_t byte_addr;
        int                  beats;
        beats = 0;
        for (int r = 0; r < NUM_REQ; r++)
        begin
            addr = req_dst[r];
            for (int i = 0; i < req_len[r]; i++)
            begin
                beats = beats + 1;
                for (int k = req_start[r]; k <= req_end[r]; k++)
                begin
                    byte_addr = req_src[r] + 16 * i + k;
                    acc.push_back(`MEM_BYTE(byte_addr));
                end
                while (acc.size() >= `FETCH_BEAT_BYTES)
                begin
                    word = '0;
                    for (int j = 0; j < `FETCH_BEAT_BYTES; j++)
                        word[8*j +: 8] = acc.pop_front();
                    add_expected(word, addr, beats, 1'b0);
                    addr = addr + `FETCH_BEAT_BYTES;
                end
            end
            // leftover bytes of the request go out zero padded
            if (acc.size() != 0)
            begin
                word = '0;
                for (int j = 0; acc.size() != 0; j++)
                    word[8*j +: 8] = acc.pop_front();
                add_expected(word, addr, beats, 1'b1);
            end
        end
        total_beats = beats;
    endtask

    // request feeder that learns of acceptance one falling edge ahead
    always @(negedge clock)
    begin
        if (resetn)
        begin
            if (req_taken)
            begin
                req_sent    = req_sent + 1;
                i_req_valid = 1'b0;
            end
            if (!i_req_valid && req_sent < NUM_REQ && $urandom_range(3, 0) != 0)
            begin
                i_req_src   = req_src[req_sent];
                i_req_len   = req_len[req_sent];
                i_req_start = req_start[req_sent];
                i_req_end   = req_end[req_sent];
                i_req_dst   = req_dst[req_sent];
                i_req_valid = 1'b1;
            end
            req_taken = i_req_valid && o_req_ready;
        end
    end

    // writer side with random done delays
    always @(negedge clock)
    begin
        i_out_done = 1'b0;
        if (resetn && o_out_valid && !hold_done)
        begin
            if (done_wait == 0)
            begin
                take_word();
                i_out_done = 1'b1;
                done_wait  = $urandom_range(3, 0);
            end
            else
                done_wait = done_wait - 1;
        end
    end

    // timeout and credit bound
    always @(posedge clock)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
            stop_with_failure($sformatf("timeout, run not done within %0d cycles", cycle_limit));
        else if (words_seen < exp_beat.size()
                 && beats_issued > exp_beat[words_seen] + `FETCH_BUF_DEPTH)
            stop_with_failure($sformatf("%0d beats issued, but only %0d can be popped plus %0d",
                                        beats_issued, exp_beat[words_seen], `FETCH_BUF_DEPTH));
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(98974));
        clock          = 1'b0;
        resetn         = 1'b0;
        i_req_valid    = 1'b0;
        i_req_src      = '0;
        i_req_len      = '0;
        i_req_start    = '0;
        i_req_end      = '0;
        i_req_dst      = '0;
        i_out_done     = 1'b0;
        req_taken      = 1'b0;
        hold_done      = 1'b0;
        saw_ready_low  = 1'b0;
        req_sent       = 0;
        words_seen     = 0;
        padded_seen    = 0;
        done_wait      = 0;
        cycles         = 0;
        make_requests();
        build_model();
        cycle_limit = 40 * total_beats + 1000;

        repeat (2)
        begin
            @(negedge clock);
            check_idle_outputs();
        end
        resetn <= 1'b1;
        @(negedge clock);
        check_idle_outputs();

        // writer stall once traffic is flowing
        @(posedge clock);
        while (req_sent < STALL_AFTER)
            @(posedge clock);
        hold_done = 1'b1;
        repeat (STALL_CYCLES)
        begin
            @(negedge clock);
            if (!o_req_ready)
                saw_ready_low = 1'b1;
        end
        // the pending word must still be offered to the writer
        check_value("o_out_valid", o_out_valid, 1'b1);
        @(posedge clock);
        hold_done = 1'b0;
        if (!saw_ready_low)
            stop_with_failure("o_req_ready stayed high through the whole writer stall");

        while (words_seen < exp_data.size())
            @(posedge clock);
        // an extra word would reach the writer in this window
        repeat (50)
            @(posedge clock);
        if (padded_seen == 0)
            stop_with_failure("no zero padded tail word was received");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== sim/mem_responder.sv ====
`include "mem_pattern.svh"

module mem_responder
(
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     i_rd_req_valid,
    input  mem_side_pkg::addr_t      i_rd_addr,
    input  mem_side_pkg::burst_len_t i_rd_len,
    output logic                     o_rd_req_ready,
    output mem_side_pkg::beat_t      o_rd_data,
    output logic                     o_rd_valid,
    output logic                     o_rd_last,
    output int                       o_beats_issued
);

    // beats still owed to the DUT, in burst order
    mem_side_pkg::addr_t beat_addr [$];
    logic                beat_last [$];
    int                  ready_wait;

    function automatic mem_side_pkg::beat_t beat_at(input mem_side_pkg::addr_t base);
        mem_side_pkg::beat_t d;
        mem_side_pkg::addr_t a;
        for (int k = 0; k < 16; k++)
        begin
            a = base + k;
            d[8*k +: 8] = `MEM_BYTE(a);
        end
        return d;
    endfunction

    initial
    begin
        o_rd_req_ready = 1'b0;
        o_rd_data      = '0;
        o_rd_valid     = 1'b0;
        o_rd_last      = 1'b0;
        o_beats_issued = 0;
        ready_wait     = 0;
    end

    always @(negedge clock)
    begin
        if (!resetn)
        begin
            o_rd_req_ready = 1'b0;
            o_rd_valid     = 1'b0;
            o_rd_last      = 1'b0;
            beat_addr.delete();
            beat_last.delete();
        end
        else
        begin
            // data channel, a beat on about three cycles out of four
            o_rd_valid = 1'b0;
            o_rd_last  = 1'b0;
            if (beat_addr.size() != 0 && $urandom_range(3, 0) != 0)
            begin
                o_rd_valid = 1'b1;
                o_rd_data  = beat_at(beat_addr.pop_front());
                o_rd_last  = beat_last.pop_front();
            end
            // address channel, the burst is taken on the coming rising edge
            o_rd_req_ready = 1'b0;
            if (i_rd_req_valid)
            begin
                if (ready_wait == 0)
                begin
                    o_rd_req_ready = 1'b1;
                    for (int i = 0; i < i_rd_len; i++)
                    begin
                        beat_addr.push_back(i_rd_addr + 16 * i);
                        beat_last.push_back(i == i_rd_len - 1);
                    end
                    o_beats_issued = o_beats_issued + i_rd_len;
                    ready_wait     = $urandom_range(3, 0);
                end
                else
                    ready_wait = ready_wait - 1;
            end
        end
    end

endmodule
